// File: Makefile
VERILATOR ?= verilator
TOP       ?= img_controller_tb
FILELIST  ?= img_controller.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/img_controller_assert.sv
`timescale 1ns/1ps

module img_controller_assert (
    input logic           clk,
    input logic           rst,
    input img_pkg::word_t readout_data,
    input logic           readout_valid,
    input logic           readout_ready,
    input logic           readout_done,
    input logic           capture_done
);

    // Stalled word stays put until taken
    hold_under_stall: assert property (@(posedge clk) disable iff (rst)
        readout_valid && !readout_ready |=> readout_valid && $stable(readout_data))
        else $error("readout word changed or dropped while stalled");

    // Done follows the last transfer, never overlaps a valid word
    done_without_valid: assert property (@(posedge clk) disable iff (rst)
        !(readout_done && readout_valid))
        else $error("readout_done high together with readout_valid");

    capture_done_single: assert property (@(posedge clk) disable iff (rst)
        capture_done |=> !capture_done)
        else $error("capture_done longer than one cycle");

endmodule

bind img_controller img_controller_assert u_assert (
    .clk           (clk),
    .rst           (rst),
    .readout_data  (readout_data),
    .readout_valid (readout_valid),
    .readout_ready (readout_ready),
    .readout_done  (readout_done),
    .capture_done  (capture_done)
);

// File: bench/img_controller_tb.sv
`timescale 1ns/1ps

module img_controller_tb;

    localparam int W            = img_pkg::DEF_IMG_WIDTH;
    localparam int H            = img_pkg::DEF_IMG_HEIGHT;
    localparam int HDR          = img_pkg::DEF_HEADER_WORDS;
    localparam int PAD          = img_pkg::DEF_PAD_WORDS;
    localparam int DEPTH        = W * H;
    localparam int CNT_W        = $clog2(DEPTH + 1);
    localparam int STREAM_WORDS = HDR + DEPTH + img_pkg::CHECKSUM_WORDS + PAD;
    // Lead-in, lines with their gaps, tail and command overhead
    localparam int FRAME_CYCLES = 3 + H * (W + 2) + 12;
    localparam int NUM_FRAMES   = 4;
    localparam int NUM_READOUTS = 4;
    // About two cycles per word, margin of 4
    localparam int TIMEOUT_CYCLES =
        4 * (NUM_FRAMES * FRAME_CYCLES + NUM_READOUTS * 2 * STREAM_WORDS);

    logic                           clk;
    logic                           rst;
    logic                           cmd_capture;
    logic                           cmd_readout;
    logic                           cmd_skip_count;
    logic                           cmd_thumb;
    logic [HDR*16-1:0]              cmd_header;
    img_pkg::pixel_t                img_d;
    logic                           img_fv;
    logic                           img_lv;
    img_pkg::word_t                 readout_data;
    logic                           readout_valid;
    logic                           readout_ready;
    logic                           readout_done;
    logic                           capture_done;
    logic [CNT_W-1:0]               pixel_count;
    logic [img_pkg::STAT_WIDTH-1:0] highlight_count;
    logic [img_pkg::STAT_WIDTH-1:0] shadow_count;

    img_pkg::pixel_t frames [2][DEPTH];
    img_pkg::word_t  exp_q [$];
    img_pkg::word_t  rx_q [$];
    logic [31:0]     lfsr_state;
    int              errors;
    int              checks;
    int              rdone_cnt;
    int              cdone_cnt;
    int              cycles;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    img_controller #(
        .IMG_WIDTH    (W),
        .IMG_HEIGHT   (H),
        .HEADER_WORDS (HDR),
        .PAD_WORDS    (PAD)
    ) dut (
        .clk             (clk),
        .rst             (rst),
        .cmd_capture     (cmd_capture),
        .cmd_readout     (cmd_readout),
        .cmd_skip_count  (cmd_skip_count),
        .cmd_thumb       (cmd_thumb),
        .cmd_header      (cmd_header),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .readout_data    (readout_data),
        .readout_valid   (readout_valid),
        .readout_ready   (readout_ready),
        .readout_done    (readout_done),
        .capture_done    (capture_done),
        .pixel_count     (pixel_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Galois LFSR stepped once for each bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic fill_random(input int sel);
        logic [31:0] r;
        for (int i = 0; i < DEPTH; i++) begin
            r = lfsr_bits(12);
            frames[sel][i] = r[11:0];
        end
    endtask

    // Grid pixels get forced extremes, column 2 and row 2 get extremes that must not count
    task automatic fill_stats(input int sel);
        logic [31:0]     r;
        img_pkg::pixel_t p;
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                r = lfsr_bits(12);
                p = r[11:0];
                if (x % 4 == 0 && y % 4 == 0) begin
                    case ((x / 4 + y / 4) % 3)
                        0: p = {7'h7f, p[4:0]};
                        1: p = {7'h00, p[4:0]};
                        default: p[11] = ~p[10];
                    endcase
                end else if (x % 4 == 2 || y % 4 == 2) begin
                    p = ((x + y) % 2 == 1) ? 12'hfff : 12'h000;
                end
                frames[sel][y * W + x] = p;
            end
        end
    endtask

    task automatic expected_stats(input int sel, output int hi, output int sh);
        img_pkg::pixel_t                   p;
        logic [img_pkg::STAT_TOP_BITS-1:0] top;
        hi = 0;
        sh = 0;
        for (int y = 0; y < H; y += 4) begin
            for (int x = 0; x < W; x += 4) begin
                p = frames[sel][y * W + x];
                top = p >> (12 - img_pkg::STAT_TOP_BITS);
                if (top == '1) begin
                    hi++;
                end else if (top == '0) begin
                    sh++;
                end
            end
        end
    endtask

    // Sensor frame with a lead-in, lines with two idle cycles between and fv low after
    task automatic drive_frame(input int sel);
        img_fv = 1'b1;
        tick(3);
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                img_lv = 1'b1;
                img_d  = frames[sel][y * W + x];
                tick(1);
            end
            img_lv = 1'b0;
            img_d  = '0;
            tick(2);
        end
        img_fv = 1'b0;
        tick(4);
    endtask

    // With skip set, frame 0 is skipped and frame 1 is captured
    task automatic capture_frames(input logic skip);
        int start;
        start = cdone_cnt;
        cmd_skip_count = skip;
        cmd_capture    = 1'b1;
        tick(1);
        cmd_capture    = 1'b0;
        cmd_skip_count = 1'b0;
        drive_frame(0);
        if (skip) begin
            drive_frame(1);
        end
        while (cdone_cnt == start) begin
            tick(1);
        end
        tick(2);
        check_value("capture_done pulses", cdone_cnt - start, 1);
        check_value("pixel_count", pixel_count, DEPTH);
    endtask

    // Fletcher-32 over everything queued so far
    function automatic logic [31:0] fletcher_ref();
        int unsigned    s1;
        int unsigned    s2;
        img_pkg::word_t w;
        s1 = 0;
        s2 = 0;
        foreach (exp_q[i]) begin
            w  = exp_q[i];
            s1 = (s1 + {w[7:0], w[15:8]}) % 65535;
            s2 = (s2 + s1) % 65535;
        end
        return {s2[15:0], s1[15:0]};
    endfunction

    task automatic build_expected(input int sel, input logic thumb);
        logic [31:0]     sum;
        img_pkg::pixel_t p;
        exp_q.delete();
        for (int h = 0; h < HDR; h++) begin
            exp_q.push_back(cmd_header[HDR * 16 - 1 - 16 * h -: 16]);
        end
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                p = frames[sel][y * W + x];
                if (!thumb || (x % 8 < 2 && y % 8 < 2)) begin
                    exp_q.push_back({p[7:0], 4'b0000, p[11:8]});
                end
            end
        end
        sum = fletcher_ref();
        exp_q.push_back({sum[7:0], sum[15:8]});
        exp_q.push_back({sum[23:16], sum[31:24]});
        for (int i = 0; i < PAD; i++) begin
            exp_q.push_back(16'h0000);
        end
    endtask

    task automatic run_readout(input logic thumb, input logic stall);
        int          start;
        logic [31:0] r;
        start = rdone_cnt;
        rx_q.delete();
        cmd_thumb   = thumb;
        cmd_readout = 1'b1;
        tick(1);
        cmd_readout = 1'b0;
        cmd_thumb   = 1'b0;
        while (rdone_cnt == start) begin
            if (stall) begin
                r = lfsr_bits(1);
                readout_ready = r[0];
            end
            tick(1);
        end
        readout_ready = 1'b1;
        tick(4);
        check_value("readout_done pulses", rdone_cnt - start, 1);
        check_value("readout_valid", readout_valid, 0);
    endtask

    task automatic compare_stream();
        check_value("readout word count", rx_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
            check_value($sformatf("readout_data[%0d]", i), rx_q[i], exp_q[i]);
        end
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic check_reset_state();
        check_value("readout_valid", readout_valid, 0);
        check_value("readout_done", readout_done, 0);
        check_value("capture_done", capture_done, 0);
        check_value("wr_en", dut.wr_en, 0);
        check_value("pixel_count", pixel_count, 0);
        check_value("highlight_count", highlight_count, 0);
        check_value("shadow_count", shadow_count, 0);
    endtask

    task automatic read_full_frame();
        fill_random(0);
        capture_frames(1'b0);
        for (int h = 0; h < HDR; h++) begin
            cmd_header[16 * h +: 16] = 16'(lfsr_bits(16));
        end
        build_expected(0, 1'b0);
        run_readout(1'b0, 1'b0);
        compare_stream();
    endtask

    // Same buffer contents and header as the full readout
    task automatic read_with_back_pressure();
        build_expected(0, 1'b0);
        run_readout(1'b0, 1'b1);
        compare_stream();
    endtask

    task automatic read_thumbnail();
        build_expected(0, 1'b1);
        run_readout(1'b1, 1'b0);
        compare_stream();
    endtask

    task automatic skip_one_frame();
        fill_random(0);
        fill_random(1);
        capture_frames(1'b1);
        build_expected(1, 1'b0);
        run_readout(1'b0, 1'b0);
        compare_stream();
    endtask

    task automatic measure_exposure();
        int hi;
        int sh;
        fill_stats(0);
        capture_frames(1'b0);
        expected_stats(0, hi, sh);
        check_value("highlight_count", highlight_count, hi);
        check_value("shadow_count", shadow_count, sh);
    endtask

    // ======================================================================
    // Monitor, watchdog and sequence
    // ======================================================================

    always @(negedge clk) begin
        if (!rst) begin
            if (readout_valid && readout_ready) begin
                rx_q.push_back(readout_data);
            end
            if (readout_done) begin
                rdone_cnt++;
            end
            if (capture_done) begin
                cdone_cnt++;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        lfsr_state     = 32'h9111_510a;
        errors         = 0;
        checks         = 0;
        rdone_cnt      = 0;
        cdone_cnt      = 0;
        cmd_capture    = 1'b0;
        cmd_readout    = 1'b0;
        cmd_skip_count = 1'b0;
        cmd_thumb      = 1'b0;
        cmd_header     = '0;
        img_d          = '0;
        img_fv         = 1'b0;
        img_lv         = 1'b0;
        readout_ready  = 1'b1;
        @(negedge rst);
        tick(1);
        check_reset_state();
        read_full_frame();
        read_with_back_pressure();
        read_thumbnail();
        skip_one_frame();
        measure_exposure();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset drops just after an edge, like the other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: capture/pixel_capture.sv
`timescale 1ns/1ps

module pixel_capture #(
    parameter int IMG_WIDTH  = img_pkg::DEF_IMG_WIDTH,
    parameter int IMG_HEIGHT = img_pkg::DEF_IMG_HEIGHT,
    localparam int DEPTH     = IMG_WIDTH * IMG_HEIGHT,
    localparam int ADDR_W    = $clog2(DEPTH),
    localparam int CNT_W     = $clog2(DEPTH + 1)
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cmd_capture,
    input  logic                           cmd_skip_count,
    input  img_pkg::pixel_t                img_d,
    input  logic                           img_fv,
    input  logic                           img_lv,
    output logic                           wr_en,
    output logic [ADDR_W-1:0]              wr_addr,
    output img_pkg::word_t                 wr_data,
    output logic                           capture_done,
    output logic [CNT_W-1:0]               pixel_count,
    output logic [img_pkg::STAT_WIDTH-1:0] highlight_count,
    output logic [img_pkg::STAT_WIDTH-1:0] shadow_count
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_START,
        ST_SKIP,
        ST_CAPTURE
    } state_t;

    state_t                            state;
    logic                              fv_q;
    logic                              lv_q;
    logic                              skip_left;
    logic [1:0]                        col;
    logic [1:0]                        row;
    logic                              store;
    logic [img_pkg::STAT_TOP_BITS-1:0] top_bits;

    // Every line-valid cycle of the captured frame stores a pixel until the buffer is full
    assign store    = (state == ST_CAPTURE) && img_lv && (pixel_count < CNT_W'(DEPTH));
    assign top_bits = img_d[$bits(img_pkg::pixel_t)-1 -: img_pkg::STAT_TOP_BITS];

    // ======================================================================
    // Edge detection and 4x4 grid position
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            fv_q <= 1'b0;
            lv_q <= 1'b0;
            col  <= '0;
            row  <= '0;
        end else begin
            fv_q <= img_fv;
            lv_q <= img_lv;
            if (!img_lv) begin
                col <= '0;
            end else begin
                col <= col + 2'd1;
            end
            // Row advances at the end of each line
            if (!img_fv) begin
                row <= '0;
            end else if (lv_q && !img_lv) begin
                row <= row + 2'd1;
            end
        end
    end

    // Low pixel byte goes to the high word byte
    always_ff @(posedge clk) begin
        wr_data <= {img_d[7:0], 4'b0000, img_d[11:8]};
        wr_addr <= pixel_count[ADDR_W-1:0];
    end

    // ======================================================================
    // Capture FSM and statistics
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= ST_IDLE;
            skip_left       <= 1'b0;
            wr_en           <= 1'b0;
            capture_done    <= 1'b0;
            pixel_count     <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            wr_en        <= store;
            capture_done <= 1'b0;

            if (store) begin
                pixel_count <= pixel_count + 1'b1;
                if (col == 2'd0 && row == 2'd0) begin
                    if (&top_bits) begin
                        highlight_count <= highlight_count + 1'b1;
                    end else if (~|top_bits) begin
                        shadow_count <= shadow_count + 1'b1;
                    end
                end
            end

            case (state)
                ST_IDLE: begin
                    if (cmd_capture) begin
                        pixel_count     <= '0;
                        highlight_count <= '0;
                        shadow_count    <= '0;
                        skip_left       <= cmd_skip_count;
                        state           <= ST_WAIT_START;
                    end
                end
                ST_WAIT_START: begin
                    if (img_fv && !fv_q) begin
                        state <= ST_SKIP;
                    end
                end
                // Each skipped frame uses up one frame start
                ST_SKIP: begin
                    skip_left <= 1'b0;
                    state     <= skip_left ? ST_WAIT_START : ST_CAPTURE;
                end
                ST_CAPTURE: begin
                    if (!img_fv) begin
                        capture_done <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: common/img_pkg.sv
package img_pkg;

    // ======================================================================
    // Data types
    // ======================================================================

    // One readout or buffer word
    typedef logic [15:0] word_t;

    // One sensor sample
    typedef logic [11:0] pixel_t;

    // ======================================================================
    // Default geometry and framing
    // ======================================================================

    localparam int DEF_IMG_WIDTH    = 16;
    localparam int DEF_IMG_HEIGHT   = 16;

    // Words sent ahead of the pixels
    localparam int DEF_HEADER_WORDS = 4;

    // Zero words sent after the checksum
    localparam int DEF_PAD_WORDS    = 3;

    // Fletcher-32 value split into 16-bit words
    localparam int CHECKSUM_WORDS   = 2;

    // ======================================================================
    // Exposure statistics
    // ======================================================================

    localparam int STAT_WIDTH       = 18;

    // Top pixel bits all ones -> highlight, all zeros -> shadow
    localparam int STAT_TOP_BITS    = 7;

endpackage

// File: hw/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer #(
    parameter int DEPTH   = img_pkg::DEF_IMG_WIDTH * img_pkg::DEF_IMG_HEIGHT,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  img_pkg::word_t    wr_data,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output img_pkg::word_t    rd_data
);

    img_pkg::word_t mem [DEPTH];

    // Write port, fed by capture
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data comes back one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: hw/img_controller.sv
`timescale 1ns/1ps

module img_controller #(
    parameter int IMG_WIDTH    = img_pkg::DEF_IMG_WIDTH,
    parameter int IMG_HEIGHT   = img_pkg::DEF_IMG_HEIGHT,
    parameter int HEADER_WORDS = img_pkg::DEF_HEADER_WORDS,
    parameter int PAD_WORDS    = img_pkg::DEF_PAD_WORDS,
    localparam int DEPTH       = IMG_WIDTH * IMG_HEIGHT,
    localparam int ADDR_W      = $clog2(DEPTH),
    localparam int CNT_W       = $clog2(DEPTH + 1)
) (
    input  logic                           clk,
    input  logic                           rst,
    // Commands
    input  logic                           cmd_capture,
    input  logic                           cmd_readout,
    input  logic                           cmd_skip_count,
    input  logic                           cmd_thumb,
    input  logic [HEADER_WORDS*16-1:0]     cmd_header,
    // Sensor
    input  img_pkg::pixel_t                img_d,
    input  logic                           img_fv,
    input  logic                           img_lv,
    // Readout stream
    output img_pkg::word_t                 readout_data,
    output logic                           readout_valid,
    input  logic                           readout_ready,
    output logic                           readout_done,
    // Capture status
    output logic                           capture_done,
    output logic [CNT_W-1:0]               pixel_count,
    output logic [img_pkg::STAT_WIDTH-1:0] highlight_count,
    output logic [img_pkg::STAT_WIDTH-1:0] shadow_count
);

    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    img_pkg::word_t    wr_data;
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    img_pkg::word_t    rd_data;

    // ======================================================================
    // Capture into the frame buffer
    // ======================================================================

    pixel_capture #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) u_capture (
        .clk             (clk),
        .rst             (rst),
        .cmd_capture     (cmd_capture),
        .cmd_skip_count  (cmd_skip_count),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .capture_done    (capture_done),
        .pixel_count     (pixel_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    frame_buffer #(
        .DEPTH (DEPTH)
    ) u_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // ======================================================================
    // Readout from the frame buffer
    // ======================================================================

    readout_sequencer #(
        .IMG_WIDTH    (IMG_WIDTH),
        .IMG_HEIGHT   (IMG_HEIGHT),
        .HEADER_WORDS (HEADER_WORDS),
        .PAD_WORDS    (PAD_WORDS)
    ) u_readout (
        .clk           (clk),
        .rst           (rst),
        .cmd_readout   (cmd_readout),
        .cmd_thumb     (cmd_thumb),
        .cmd_header    (cmd_header),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .readout_data  (readout_data),
        .readout_valid (readout_valid),
        .readout_ready (readout_ready),
        .readout_done  (readout_done)
    );

endmodule

// File: img_controller.f
common/img_pkg.sv
capture/pixel_capture.sv
hw/frame_buffer.sv
readout/fletcher_checksum.sv
readout/readout_sequencer.sv
hw/img_controller.sv
bench/tb_clock.sv
bench/img_controller_assert.sv
bench/img_controller_tb.sv

// File: readout/fletcher_checksum.sv
`timescale 1ns/1ps

module fletcher_checksum (
    input  logic           clk,
    input  logic           rst,
    input  logic           sum_clear,
    input  logic           sum_en,
    input  img_pkg::word_t sum_word,
    output logic [31:0]    sum_value
);

    logic [15:0] sum1;
    logic [15:0] sum2;
    logic [15:0] sum1_next;

    // Addition modulo 65535
    function automatic logic [15:0] mod_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= 17'd65535) begin
            s = s - 17'd65535;
        end
        return s[15:0];
    endfunction

    // Words enter little endian
    assign sum1_next = mod_add(sum1, {sum_word[7:0], sum_word[15:8]});
    assign sum_value = {sum2, sum1};

    always_ff @(posedge clk) begin
        if (rst || sum_clear) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (sum_en) begin
            sum1 <= sum1_next;
            sum2 <= mod_add(sum2, sum1_next);
        end
    end

endmodule

// File: readout/readout_sequencer.sv
`timescale 1ns/1ps

module readout_sequencer #(
    parameter int IMG_WIDTH    = img_pkg::DEF_IMG_WIDTH,
    parameter int IMG_HEIGHT   = img_pkg::DEF_IMG_HEIGHT,
    parameter int HEADER_WORDS = img_pkg::DEF_HEADER_WORDS,
    parameter int PAD_WORDS    = img_pkg::DEF_PAD_WORDS,
    localparam int DEPTH       = IMG_WIDTH * IMG_HEIGHT,
    localparam int ADDR_W      = $clog2(DEPTH),
    localparam int HDR_W       = HEADER_WORDS * 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_readout,
    input  logic              cmd_thumb,
    input  logic [HDR_W-1:0]  cmd_header,
    output logic              rd_en,
    output logic [ADDR_W-1:0] rd_addr,
    input  img_pkg::word_t    rd_data,
    output img_pkg::word_t    readout_data,
    output logic              readout_valid,
    input  logic              readout_ready,
    output logic              readout_done
);

    localparam int TAIL_WORDS = img_pkg::CHECKSUM_WORDS + PAD_WORDS;
    localparam int MAX_WORDS  = (HEADER_WORDS > TAIL_WORDS) ? HEADER_WORDS : TAIL_WORDS;
    localparam int CNT_W      = $clog2(MAX_WORDS + 1);
    localparam int X_W        = ($clog2(IMG_WIDTH) < 3) ? 3 : $clog2(IMG_WIDTH);
    localparam int Y_W        = ($clog2(IMG_HEIGHT) < 3) ? 3 : $clog2(IMG_HEIGHT);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PIXELS,
        ST_SUM_WAIT,
        ST_TAIL,
        ST_DRAIN
    } state_t;

    state_t                                state;
    logic [HDR_W-1:0]                      hdr_shift;
    logic [img_pkg::CHECKSUM_WORDS*16-1:0] tail_shift;
    logic [CNT_W-1:0]                      cnt;
    logic                                  thumb_q;
    logic [X_W-1:0]                        x;
    logic [Y_W-1:0]                        y;
    logic                                  rd_pend;
    logic                                  data_sum;
    logic                                  load;
    logic                                  xfer;
    logic                                  keep;
    logic                                  step;
    logic                                  sum_clear;
    logic                                  sum_en;
    logic [31:0]                           sum_value;

    // Output register is free when empty or drained this cycle
    assign load = !readout_valid || readout_ready;
    assign xfer = readout_valid && readout_ready;

    // Thumbnail keeps the upper-left 2x2 of every 8x8 block
    assign keep = !thumb_q || (x[2:1] == 2'b00 && y[2:1] == 2'b00);

    // Dropped pixels advance at once, kept ones wait for a free register
    assign step  = (state == ST_PIXELS) && !rd_pend && (!keep || load);
    assign rd_en = step && keep;

    assign sum_clear = (state == ST_IDLE) && cmd_readout;
    assign sum_en    = xfer && data_sum;

    fletcher_checksum u_checksum (
        .clk       (clk),
        .rst       (rst),
        .sum_clear (sum_clear),
        .sum_en    (sum_en),
        .sum_word  (readout_data),
        .sum_value (sum_value)
    );

    // ======================================================================
    // Readout FSM
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            readout_valid <= 1'b0;
            readout_done  <= 1'b0;
            rd_pend       <= 1'b0;
            data_sum      <= 1'b0;
        end else begin
            readout_done <= 1'b0;
            rd_pend      <= rd_en;
            if (xfer) begin
                readout_valid <= 1'b0;
            end

            // Pixel lands in the register that was free when its read issued
            if (rd_pend) begin
                readout_data  <= rd_data;
                readout_valid <= 1'b1;
                data_sum      <= 1'b1;
            end

            case (state)
                ST_IDLE: begin
                    if (cmd_readout) begin
                        hdr_shift <= cmd_header;
                        thumb_q   <= cmd_thumb;
                        cnt       <= CNT_W'(HEADER_WORDS);
                        rd_addr   <= '0;
                        x         <= '0;
                        y         <= '0;
                        state     <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (load) begin
                        readout_data  <= hdr_shift[HDR_W-1 -: 16];
                        readout_valid <= 1'b1;
                        data_sum      <= 1'b1;
                        hdr_shift     <= hdr_shift << 16;
                        cnt           <= cnt - 1'b1;
                        if (cnt == CNT_W'(1)) begin
                            state <= ST_PIXELS;
                        end
                    end
                end
                ST_PIXELS: begin
                    if (step) begin
                        rd_addr <= rd_addr + 1'b1;
                        if (x == X_W'(IMG_WIDTH - 1)) begin
                            x <= '0;
                            y <= y + 1'b1;
                        end else begin
                            x <= x + 1'b1;
                        end
                        if (rd_addr == ADDR_W'(DEPTH - 1)) begin
                            state <= ST_SUM_WAIT;
                        end
                    end
                end
                // Sum is final once the last summed word has gone out
                ST_SUM_WAIT: begin
                    if (!rd_pend && !(readout_valid && data_sum)) begin
                        tail_shift <= {sum_value[7:0], sum_value[15:8],
                                       sum_value[23:16], sum_value[31:24]};
                        cnt        <= CNT_W'(TAIL_WORDS);
                        state      <= ST_TAIL;
                    end
                end
                // Checksum words, then zeros shifted in as padding
                ST_TAIL: begin
                    if (load) begin
                        readout_data  <= tail_shift[$bits(tail_shift)-1 -: 16];
                        readout_valid <= 1'b1;
                        data_sum      <= 1'b0;
                        tail_shift    <= tail_shift << 16;
                        cnt           <= cnt - 1'b1;
                        if (cnt == CNT_W'(1)) begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (xfer) begin
                        readout_done <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule
